// ==== hw/rv_isa_pkg.sv ====
`default_nettype none

package rv_isa_pkg;

    localparam int xlen        = 32;
    localparam int reg_idx_w   = 5;
    localparam int imem_addr_w = 12;

    typedef logic [xlen-1:0]        word_t;
    typedef logic [reg_idx_w-1:0]   reg_idx_t;
    typedef logic [imem_addr_w-1:0] imem_addr_t;
    // only the low bits of src2 take part in a shift
    typedef logic [4:0]             shamt_t;

    // one code per decoded instruction class
    typedef enum logic [4:0] {
        op_nop,
        op_add, op_sub, op_slt, op_sltu,
        op_xor, op_or, op_and,
        op_sll, op_srl, op_sra,
        op_lui, op_auipc,
        op_jal, op_jalr,
        op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu,
        op_lb, op_lh, op_lw, op_lbu, op_lhu,
        op_sb, op_sh, op_sw
    } ex_op_t;

    // issue request from the decoder
    typedef struct packed {
        ex_op_t   op;
        word_t    src1;
        word_t    src2;
        // branch or store offset
        word_t    imm;
        word_t    pc;
        reg_idx_t wb_addr;
        logic     wb_en;
    } ex_req_t;

endpackage

`default_nettype wire

// ==== hw/ex_mem_pkg.sv ====
`default_nettype none

package ex_mem_pkg;

    localparam int sram_addr_size = 13;
    // bank code sits right above the sram offset
    localparam int sram_sel_lsb   = 13;
    localparam int sram_sel_size  = 2;

    typedef logic [sram_addr_size-1:0] sram_addr_t;

    typedef enum logic [sram_sel_size-1:0] {
        sel_iram = 2'b00,
        sel_oram = 2'b01,
        sel_wram = 2'b10,
        sel_none = 2'b11
    } sram_sel_t;

    typedef enum logic [3:0] {
        mem_none,
        mem_lb, mem_lh, mem_lw, mem_lbu, mem_lhu,
        mem_sb, mem_sh, mem_sw
    } mem_op_t;

    // request handed to the load/store unit
    typedef struct packed {
        mem_op_t              mem_op;
        sram_sel_t            sram_sel;
        sram_addr_t           sram_addr;
        rv_isa_pkg::word_t    st_data;
        rv_isa_pkg::reg_idx_t wb_addr;
        rv_isa_pkg::word_t    wb_data;
        logic                 wb_en;
    } lsu_req_t;

endpackage

`default_nettype wire

// ==== hw/ex_redirect.sv ====
`default_nettype none

module ex_redirect (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire logic                req_vld,
    input  wire rv_isa_pkg::ex_req_t req,
    input  wire logic                lsu_rdy,
    output logic                     accept,
    output logic                     is_branch,
    output logic                     br_vld,
    output rv_isa_pkg::imem_addr_t   br_addr
);

    logic              is_jal;
    logic              is_jalr;
    logic              taken;
    logic              lt_s;
    logic              lt_u;
    logic              eq;
    logic              br_vld_nxt;
    rv_isa_pkg::word_t target;

    // squash whatever is presented while a redirect is out
    assign accept = req_vld & lsu_rdy & ~br_vld;

    assign is_jal    = (req.op == rv_isa_pkg::op_jal);
    assign is_jalr   = (req.op == rv_isa_pkg::op_jalr);
    assign is_branch = (req.op == rv_isa_pkg::op_beq)
                     | (req.op == rv_isa_pkg::op_bne)
                     | (req.op == rv_isa_pkg::op_blt)
                     | (req.op == rv_isa_pkg::op_bge)
                     | (req.op == rv_isa_pkg::op_bltu)
                     | (req.op == rv_isa_pkg::op_bgeu);

    assign eq   = (req.src1 == req.src2);
    assign lt_s = ($signed(req.src1) < $signed(req.src2));
    assign lt_u = (req.src1 < req.src2);

    always_comb begin
        case (req.op)
            rv_isa_pkg::op_beq:  taken = eq;
            rv_isa_pkg::op_bne:  taken = ~eq;
            rv_isa_pkg::op_blt:  taken = lt_s;
            rv_isa_pkg::op_bge:  taken = ~lt_s;
            rv_isa_pkg::op_bltu: taken = lt_u;
            rv_isa_pkg::op_bgeu: taken = ~lt_u;
            default:             taken = 1'b0;
        endcase
    end

    // jal offset arrives on src2, branch offset on imm
    always_comb begin
        if (is_jal) begin
            target = req.pc + req.src2;
        end else if (is_jalr) begin
            target = req.src1 + req.src2;
        end else begin
            target = req.pc + req.imm;
        end
    end

    assign br_vld_nxt = accept & (taken | is_jal | is_jalr);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            br_vld <= 1'b0;
        end else begin
            br_vld <= br_vld_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            br_addr <= target[rv_isa_pkg::imem_addr_w-1:0];
        end
    end

endmodule

`default_nettype wire

// ==== hw/ex_int_alu.sv ====
`default_nettype none

module ex_int_alu (
    input  wire rv_isa_pkg::ex_req_t req,
    output rv_isa_pkg::word_t        result
);

    rv_isa_pkg::shamt_t shamt;
    rv_isa_pkg::word_t  sum;
    rv_isa_pkg::word_t  diff;
    rv_isa_pkg::word_t  link;
    logic               lt_s;
    logic               lt_u;

    assign shamt = req.src2[4:0];
    assign sum   = req.src1 + req.src2;
    assign diff  = req.src1 - req.src2;
    // return address for jal/jalr
    assign link  = req.pc + 32'd4;
    assign lt_s  = ($signed(req.src1) < $signed(req.src2));
    assign lt_u  = (req.src1 < req.src2);

    always_comb begin
        case (req.op)
            rv_isa_pkg::op_add: begin
                result = sum;
            end
            rv_isa_pkg::op_sub: begin
                result = diff;
            end
            rv_isa_pkg::op_slt: begin
                result = {{(rv_isa_pkg::xlen-1){1'b0}}, lt_s};
            end
            rv_isa_pkg::op_sltu: begin
                result = {{(rv_isa_pkg::xlen-1){1'b0}}, lt_u};
            end
            rv_isa_pkg::op_xor: begin
                result = req.src1 ^ req.src2;
            end
            rv_isa_pkg::op_or: begin
                result = req.src1 | req.src2;
            end
            rv_isa_pkg::op_and: begin
                result = req.src1 & req.src2;
            end
            rv_isa_pkg::op_sll: begin
                result = req.src1 << shamt;
            end
            rv_isa_pkg::op_srl: begin
                result = req.src1 >> shamt;
            end
            rv_isa_pkg::op_sra: begin
                // sign fill from bit 31
                result = $signed(req.src1) >>> shamt;
            end
            rv_isa_pkg::op_lui: begin
                result = req.src2;
            end
            rv_isa_pkg::op_auipc: begin
                result = req.pc + req.src2;
            end
            rv_isa_pkg::op_jal, rv_isa_pkg::op_jalr: begin
                result = link;
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/ex_lsu_addr.sv ====
`default_nettype none

module ex_lsu_addr (
    input  wire rv_isa_pkg::ex_req_t req,
    output ex_mem_pkg::mem_op_t      mem_op,
    output ex_mem_pkg::sram_sel_t    sram_sel,
    output ex_mem_pkg::sram_addr_t   sram_addr
);

    logic              is_store;
    rv_isa_pkg::word_t addr;

    always_comb begin
        case (req.op)
            rv_isa_pkg::op_lb:  mem_op = ex_mem_pkg::mem_lb;
            rv_isa_pkg::op_lh:  mem_op = ex_mem_pkg::mem_lh;
            rv_isa_pkg::op_lw:  mem_op = ex_mem_pkg::mem_lw;
            rv_isa_pkg::op_lbu: mem_op = ex_mem_pkg::mem_lbu;
            rv_isa_pkg::op_lhu: mem_op = ex_mem_pkg::mem_lhu;
            rv_isa_pkg::op_sb:  mem_op = ex_mem_pkg::mem_sb;
            rv_isa_pkg::op_sh:  mem_op = ex_mem_pkg::mem_sh;
            rv_isa_pkg::op_sw:  mem_op = ex_mem_pkg::mem_sw;
            default:            mem_op = ex_mem_pkg::mem_none;
        endcase
    end

    assign is_store = (mem_op == ex_mem_pkg::mem_sb)
                    | (mem_op == ex_mem_pkg::mem_sh)
                    | (mem_op == ex_mem_pkg::mem_sw);

    // loads take the offset on src2, stores on imm
    assign addr = req.src1 + (is_store ? req.imm : req.src2);

    always_comb begin
        if (mem_op == ex_mem_pkg::mem_none) begin
            sram_sel  = ex_mem_pkg::sel_none;
            sram_addr = '0;
        end else begin
            sram_sel  = ex_mem_pkg::sram_sel_t'(
                addr[ex_mem_pkg::sram_sel_lsb +: ex_mem_pkg::sram_sel_size]);
            sram_addr = addr[ex_mem_pkg::sram_addr_size-1:0];
        end
    end

endmodule

`default_nettype wire

// ==== hw/ex_lsu_reg.sv ====
`default_nettype none

module ex_lsu_reg (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire logic                 accept,
    input  wire logic                 is_branch,
    input  wire logic                 lsu_rdy,
    input  wire ex_mem_pkg::lsu_req_t next_req,
    output logic                      lsu_vld,
    output ex_mem_pkg::lsu_req_t      lsu_req
);

    logic                 vld_q;
    logic                 wb_en_q;
    logic                 vld_nxt;
    logic                 wb_en_nxt;
    ex_mem_pkg::lsu_req_t data_q;

    // branches end here, everything else goes on to the lsu
    assign vld_nxt   = (accept & ~is_branch) | (vld_q & ~lsu_rdy);
    assign wb_en_nxt = (accept & ~is_branch & next_req.wb_en) | (wb_en_q & ~lsu_rdy);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vld_q   <= 1'b0;
            wb_en_q <= 1'b0;
        end else begin
            vld_q   <= vld_nxt;
            wb_en_q <= wb_en_nxt;
        end
    end

    // accept needs lsu_rdy, so a stalled entry is never overwritten
    always_ff @(posedge clk) begin
        if (accept) begin
            data_q <= next_req;
        end
    end

    always_comb begin
        lsu_req       = data_q;
        lsu_req.wb_en = wb_en_q;
    end

    assign lsu_vld = vld_q;

endmodule

`default_nettype wire

// ==== hw/ex_stage.sv ====
`default_nettype none

module ex_stage (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    // decoder side
    input  wire logic                   req_vld,
    input  wire rv_isa_pkg::ex_req_t    req,
    output logic                        idu_rdy,
    output logic                        wb_vld,
    output rv_isa_pkg::reg_idx_t        wb_addr,
    output rv_isa_pkg::word_t           wb_data,
    output logic                        ld_vld,
    output logic                        flush,
    // fetch side
    output logic                        br_vld,
    output rv_isa_pkg::imem_addr_t      br_addr,
    // load/store unit
    input  wire logic                   lsu_rdy,
    output logic                        lsu_vld,
    output ex_mem_pkg::lsu_req_t        lsu_req
);

    logic                   accept;
    logic                   is_branch;
    rv_isa_pkg::word_t      alu_result;
    ex_mem_pkg::mem_op_t    mem_op;
    ex_mem_pkg::sram_sel_t  sram_sel;
    ex_mem_pkg::sram_addr_t sram_addr;
    ex_mem_pkg::lsu_req_t   next_req;

    ex_redirect u_redirect (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_vld   (req_vld),
        .req       (req),
        .lsu_rdy   (lsu_rdy),
        .accept    (accept),
        .is_branch (is_branch),
        .br_vld    (br_vld),
        .br_addr   (br_addr)
    );

    ex_int_alu u_int_alu (
        .req    (req),
        .result (alu_result)
    );

    ex_lsu_addr u_lsu_addr (
        .req       (req),
        .mem_op    (mem_op),
        .sram_sel  (sram_sel),
        .sram_addr (sram_addr)
    );

    // loads and stores carry a zero result from the alu
    assign next_req.mem_op    = mem_op;
    assign next_req.sram_sel  = sram_sel;
    assign next_req.sram_addr = sram_addr;
    assign next_req.st_data   = req.src2;
    assign next_req.wb_addr   = req.wb_addr;
    assign next_req.wb_data   = alu_result;
    assign next_req.wb_en     = req.wb_en;

    ex_lsu_reg u_lsu_reg (
        .clk       (clk),
        .rst_n     (rst_n),
        .accept    (accept),
        .is_branch (is_branch),
        .lsu_rdy   (lsu_rdy),
        .next_req  (next_req),
        .lsu_vld   (lsu_vld),
        .lsu_req   (lsu_req)
    );

    assign idu_rdy = lsu_rdy;
    assign flush   = br_vld;

    // same-cycle writeback to the decoder
    assign wb_vld  = accept & req.wb_en;
    assign wb_addr = req.wb_addr;
    assign wb_data = alu_result;

    // raw op decode, not qualified by valid
    assign ld_vld = (mem_op == ex_mem_pkg::mem_lb)
                  | (mem_op == ex_mem_pkg::mem_lh)
                  | (mem_op == ex_mem_pkg::mem_lw)
                  | (mem_op == ex_mem_pkg::mem_lbu)
                  | (mem_op == ex_mem_pkg::mem_lhu);

endmodule

`default_nettype wire

// ==== verification/ex_stage_assertions.sv ====
`default_nettype none

module ex_stage_assertions (
    input wire logic                 clk,
    input wire logic                 rst_n,
    input wire logic                 br_vld,
    input wire logic                 wb_vld,
    input wire logic                 lsu_vld,
    input wire logic                 lsu_rdy,
    input wire ex_mem_pkg::lsu_req_t lsu_req
);

    // a redirect is a single-cycle pulse
    property br_single_pulse;
        @(posedge clk) disable iff (!rst_n)
            br_vld |=> !br_vld;
    endproperty

    property lsu_hold_on_stall;
        @(posedge clk) disable iff (!rst_n)
            (lsu_vld && !lsu_rdy) |=> (lsu_vld && $stable(lsu_req));
    endproperty

    // requests seen during a redirect are squashed
    property no_wb_during_redirect;
        @(posedge clk) disable iff (!rst_n)
            !(wb_vld && br_vld);
    endproperty

    a_br_single_pulse: assert property (br_single_pulse)
        else $error("br_vld high for two cycles in a row");
    a_lsu_hold: assert property (lsu_hold_on_stall)
        else $error("lsu request changed while stalled");
    a_no_wb_redirect: assert property (no_wb_during_redirect)
        else $error("wb_vld high during br_vld");

endmodule

`default_nettype wire

// ==== verification/ex_stage_tb.sv ====
`default_nettype none

module ex_stage_tb;

    localparam int          timeout_cycles = 50;
    localparam logic [31:0] pc_base        = 32'h100;

    typedef struct packed {
        rv_isa_pkg::ex_op_t    op;
        logic [31:0]           src1;
        logic [31:0]           src2;
        logic [31:0]           imm;
        logic                  stall;
        logic [31:0]           res;
        logic                  taken;
        logic [11:0]           tgt;
        ex_mem_pkg::mem_op_t   mem;
        ex_mem_pkg::sram_sel_t sel;
        logic [12:0]           addr;
    } entry_t;

    logic                     clk;
    logic                     rst_n;
    logic                     req_vld;
    rv_isa_pkg::ex_req_t      req;
    logic                     idu_rdy;
    logic                     wb_vld;
    rv_isa_pkg::reg_idx_t     wb_addr;
    rv_isa_pkg::word_t        wb_data;
    logic                     ld_vld;
    logic                     flush;
    logic                     br_vld;
    rv_isa_pkg::imem_addr_t   br_addr;
    logic                     lsu_rdy;
    logic                     lsu_vld;
    ex_mem_pkg::lsu_req_t     lsu_req;

    entry_t tbl[$];
    integer seed;
    int     test_errs;
    int     passed;
    int     failed;

    ex_stage DUT (
        .clk     (clk),
        .rst_n   (rst_n),
        .req_vld (req_vld),
        .req     (req),
        .idu_rdy (idu_rdy),
        .wb_vld  (wb_vld),
        .wb_addr (wb_addr),
        .wb_data (wb_data),
        .ld_vld  (ld_vld),
        .flush   (flush),
        .br_vld  (br_vld),
        .br_addr (br_addr),
        .lsu_rdy (lsu_rdy),
        .lsu_vld (lsu_vld),
        .lsu_req (lsu_req)
    );

    bind ex_stage ex_stage_assertions u_assertions (
        .clk     (clk),
        .rst_n   (rst_n),
        .br_vld  (br_vld),
        .wb_vld  (wb_vld),
        .lsu_vld (lsu_vld),
        .lsu_rdy (lsu_rdy),
        .lsu_req (lsu_req)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic is_cond_branch(input rv_isa_pkg::ex_op_t op);
        return op inside {rv_isa_pkg::op_beq, rv_isa_pkg::op_bne, rv_isa_pkg::op_blt,
                          rv_isa_pkg::op_bge, rv_isa_pkg::op_bltu, rv_isa_pkg::op_bgeu};
    endfunction

    function automatic logic is_load(input rv_isa_pkg::ex_op_t op);
        return op inside {rv_isa_pkg::op_lb, rv_isa_pkg::op_lh, rv_isa_pkg::op_lw,
                          rv_isa_pkg::op_lbu, rv_isa_pkg::op_lhu};
    endfunction

    function automatic logic is_store(input rv_isa_pkg::ex_op_t op);
        return op inside {rv_isa_pkg::op_sb, rv_isa_pkg::op_sh, rv_isa_pkg::op_sw};
    endfunction

    function automatic rv_isa_pkg::ex_req_t make_req(input entry_t e, input int idx);
        rv_isa_pkg::ex_req_t r;
        r.op      = e.op;
        r.src1    = e.src1;
        r.src2    = e.src2;
        r.imm     = e.imm;
        r.pc      = pc_base;
        r.wb_addr = 5'(idx + 1);
        r.wb_en   = !(is_store(e.op) || is_cond_branch(e.op));
        return r;
    endfunction

    task automatic int_row(input rv_isa_pkg::ex_op_t op, input logic [31:0] s1, s2, imm,
                           input logic stall, input logic [31:0] res, input logic taken,
                           input logic [11:0] tgt);
        entry_t e;
        e = '{op, s1, s2, imm, stall, res, taken, tgt,
              ex_mem_pkg::mem_none, ex_mem_pkg::sel_none, 13'h0};
        tbl.push_back(e);
    endtask

    task automatic mem_row(input rv_isa_pkg::ex_op_t op, input logic [31:0] s1, s2, imm,
                           input logic stall, input ex_mem_pkg::mem_op_t mem,
                           input ex_mem_pkg::sram_sel_t sel, input logic [12:0] addr);
        entry_t e;
        e = '{op, s1, s2, imm, stall, 32'h0, 1'b0, 12'h0, mem, sel, addr};
        tbl.push_back(e);
    endtask

    // expected values worked out by hand, pc is pc_base
    task automatic fill_table();
        int_row(rv_isa_pkg::op_add, 32'h5, 32'h7, 32'h0, 1, 32'hc, 0, 12'h0);
        int_row(rv_isa_pkg::op_sub, 32'h5, 32'h7, 32'h0, 0, 32'hffff_fffe, 0, 12'h0);
        int_row(rv_isa_pkg::op_slt, 32'hffff_fffe, 32'h1, 32'h0, 0, 32'h1, 0, 12'h0);
        int_row(rv_isa_pkg::op_sltu, 32'hffff_fffe, 32'h1, 32'h0, 0, 32'h0, 0, 12'h0);
        int_row(rv_isa_pkg::op_xor, 32'hf0f0_00ff, 32'h0ff0_0f0f, 0, 1, 32'hff00_0ff0, 0, 0);
        int_row(rv_isa_pkg::op_or, 32'ha5a5_0000, 32'h5a5a, 32'h0, 0, 32'ha5a5_5a5a, 0, 0);
        int_row(rv_isa_pkg::op_and, 32'hff00_ff00, 32'h0ff0_0ff0, 0, 0, 32'h0f00_0f00, 0, 0);
        // shift amount uses only the low five bits of src2
        int_row(rv_isa_pkg::op_sll, 32'h1, 32'h24, 32'h0, 0, 32'h10, 0, 12'h0);
        int_row(rv_isa_pkg::op_srl, 32'h8000_0000, 32'h4, 32'h0, 0, 32'h0800_0000, 0, 0);
        int_row(rv_isa_pkg::op_sra, 32'h8000_0000, 32'h4, 32'h0, 0, 32'hf800_0000, 0, 0);
        int_row(rv_isa_pkg::op_lui, 32'h0, 32'h1234_5000, 32'h0, 0, 32'h1234_5000, 0, 0);
        int_row(rv_isa_pkg::op_auipc, 32'h0, 32'h2000, 32'h0, 0, 32'h2100, 0, 12'h0);
        int_row(rv_isa_pkg::op_nop, 32'h5, 32'h7, 32'h0, 1, 32'h0, 0, 12'h0);
        int_row(rv_isa_pkg::op_jal, 32'h0, 32'h40, 32'h0, 0, 32'h104, 1, 12'h140);
        int_row(rv_isa_pkg::op_jalr, 32'h200, 32'h10, 32'h0, 0, 32'h104, 1, 12'h210);
        int_row(rv_isa_pkg::op_beq, 32'h5, 32'h5, 32'h20, 0, 32'h0, 1, 12'h120);
        int_row(rv_isa_pkg::op_bne, 32'h5, 32'h5, 32'h20, 0, 32'h0, 0, 12'h0);
        int_row(rv_isa_pkg::op_blt, 32'hffff_ffff, 32'h1, 32'h8, 0, 32'h0, 1, 12'h108);
        int_row(rv_isa_pkg::op_bltu, 32'hffff_ffff, 32'h1, 32'h8, 0, 32'h0, 0, 12'h0);
        int_row(rv_isa_pkg::op_bge, 32'h1, 32'hffff_ffff, 32'hffff_fff0, 0, 0, 1, 12'h0f0);
        int_row(rv_isa_pkg::op_bgeu, 32'h1, 32'hffff_ffff, 32'h8, 0, 32'h0, 0, 12'h0);
        mem_row(rv_isa_pkg::op_lw, 32'h2000, 32'h10, 32'h0, 1,
                ex_mem_pkg::mem_lw, ex_mem_pkg::sel_oram, 13'h0010);
        mem_row(rv_isa_pkg::op_lb, 32'h4000, 32'h4, 32'h0, 0,
                ex_mem_pkg::mem_lb, ex_mem_pkg::sel_wram, 13'h0004);
        mem_row(rv_isa_pkg::op_lhu, 32'h0, 32'h1ffe, 32'h0, 0,
                ex_mem_pkg::mem_lhu, ex_mem_pkg::sel_iram, 13'h1ffe);
        mem_row(rv_isa_pkg::op_sw, 32'h6000, 32'hdead_beef, 32'h8, 1,
                ex_mem_pkg::mem_sw, ex_mem_pkg::sel_none, 13'h0008);
        mem_row(rv_isa_pkg::op_sh, 32'h100, 32'h1234, 32'h2, 1,
                ex_mem_pkg::mem_sh, ex_mem_pkg::sel_iram, 13'h0102);
        mem_row(rv_isa_pkg::op_lbu, 32'h3ffc, 32'h1, 32'h0, 1,
                ex_mem_pkg::mem_lbu, ex_mem_pkg::sel_oram, 13'h1ffd);
    endtask

    task automatic check_val(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error at time %0t: %s is %h, expected %h", $time, what, got, exp);
            test_errs++;
        end
    endtask

    task automatic close_test(input int idx, input string name);
        if (test_errs == 0) begin
            passed++;
            $display("test %0d (%s) ok", idx, name);
        end else begin
            failed++;
            $display("test %0d (%s) failed with %0d errors", idx, name, test_errs);
        end
    endtask

    initial begin
        entry_t               e;
        rv_isa_pkg::ex_req_t  r;
        rv_isa_pkg::ex_req_t  probe;
        ex_mem_pkg::lsu_req_t snap;
        int                   cycles;
        int                   n_stall;
        logic                 got;
        logic                 timed_out;
        seed      = 67518;
        passed    = 0;
        failed    = 0;
        timed_out = 1'b0;
        rst_n     = 1'b0;
        req_vld   = 1'b0;
        req       = '0;
        lsu_rdy   = 1'b1;
        fill_table();
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        test_errs = 0;
        check_val("lsu_vld after reset", 32'(lsu_vld), 32'h0);
        check_val("br_vld after reset", 32'(br_vld), 32'h0);
        close_test(0, "reset");

        for (int i = 0; i < tbl.size(); i++) begin
            e         = tbl[i];
            r         = make_req(e, i);
            test_errs = 0;
            @(posedge clk);
            req_vld <= 1'b1;
            req     <= r;
            cycles  = 0;
            got     = 1'b0;
            while (!got && cycles < timeout_cycles) begin
                @(negedge clk);
                if (idu_rdy && !br_vld) begin
                    got = 1'b1;
                end else begin
                    cycles++;
                    @(posedge clk);
                end
            end
            if (!got) begin
                $display("test %0d (%s) timed out waiting for the stage to accept it",
                         i + 1, e.op.name());
                timed_out = 1'b1;
                break;
            end
            // accept cycle, writeback is combinational
            check_val("wb_vld", 32'(wb_vld), 32'(r.wb_en));
            check_val("wb_data", wb_data, e.res);
            check_val("wb_addr", 32'(wb_addr), 32'(r.wb_addr));
            check_val("ld_vld", 32'(ld_vld), 32'(is_load(e.op)));

            @(posedge clk);
            if (e.taken || e.stall) begin
                // a different request waits behind the redirect or the stall
                probe       = r;
                probe.op    = rv_isa_pkg::op_add;
                probe.src1  = ~r.src1;
                probe.wb_en = 1'b1;
                req <= probe;
            end else begin
                req_vld <= 1'b0;
            end
            lsu_rdy <= !e.stall;
            @(negedge clk);
            check_val("br_vld", 32'(br_vld), 32'(e.taken));
            check_val("flush", 32'(flush), 32'(e.taken));
            if (e.taken) begin
                check_val("br_addr", 32'(br_addr), 32'(e.tgt));
                check_val("wb_vld during redirect", 32'(wb_vld), 32'h0);
            end
            check_val("lsu_vld", 32'(lsu_vld), 32'(!is_cond_branch(e.op)));
            if (!is_cond_branch(e.op)) begin
                check_val("lsu mem_op", 32'(lsu_req.mem_op), 32'(e.mem));
                check_val("lsu sram_sel", 32'(lsu_req.sram_sel), 32'(e.sel));
                check_val("lsu sram_addr", 32'(lsu_req.sram_addr), 32'(e.addr));
                check_val("lsu st_data", lsu_req.st_data, e.src2);
                check_val("lsu wb_data", lsu_req.wb_data, e.res);
                check_val("lsu wb_en", 32'(lsu_req.wb_en), 32'(r.wb_en));
                check_val("lsu wb_addr", 32'(lsu_req.wb_addr), 32'(r.wb_addr));
            end
            if (e.taken) begin
                @(posedge clk);
                req_vld <= 1'b0;
                @(negedge clk);
                check_val("br_vld second cycle", 32'(br_vld), 32'h0);
                check_val("lsu_vld of squashed request", 32'(lsu_vld), 32'h0);
            end
            if (e.stall) begin
                snap    = lsu_req;
                n_stall = 1 + ($unsigned($random(seed)) % 4);
                check_val("idu_rdy on stall", 32'(idu_rdy), 32'h0);
                repeat (n_stall) begin
                    @(posedge clk);
                    @(negedge clk);
                    check_val("lsu_vld on stall", 32'(lsu_vld), 32'h1);
                    check_val("idu_rdy on stall", 32'(idu_rdy), 32'h0);
                    check_val("wb_vld on stall", 32'(wb_vld), 32'h0);
                    if (lsu_req !== snap) begin
                        $display("** Error at time %0t: lsu_req changed during stall", $time);
                        test_errs++;
                    end
                end
                @(posedge clk);
                lsu_rdy <= 1'b1;
                req_vld <= 1'b0;
            end
            close_test(i + 1, e.op.name());
        end

        $display("tests %0d, passed %0d, failed %0d", passed + failed, passed, failed);
        if (timed_out || failed != 0) begin
            $display("Simulation FAILED");
        end else begin
            $display("Simulation PASSED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
hw/rv_isa_pkg.sv
hw/ex_mem_pkg.sv
hw/ex_redirect.sv
hw/ex_int_alu.sv
hw/ex_lsu_addr.sv
hw/ex_lsu_reg.sv
hw/ex_stage.sv
verification/ex_stage_assertions.sv
verification/ex_stage_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the ex_stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module ex_stage_tb -f tb.f \
    -o ex_stage_sim > build.log 2>&1 \
    && ./obj_dir/ex_stage_sim > sim.log 2>&1 \
    || { echo "build or simulation error, see build.log and sim.log"; exit 1; }

cat sim.log
grep -q "Simulation FAILED" sim.log && exit 1 || exit 0
